//--- compile.f
logic/axi_fifo_pkg.sv
logic/data_fifo.sv
logic/burst_arbiter.sv
logic/read_beat_engine.sv
logic/write_beat_engine.sv
logic/axi_fifo_slave.sv
tests/tb_axi_fifo_slave.sv

//--- tests/tb_axi_fifo_slave.sv
`default_nettype none

module tb_axi_fifo_slave import axi_fifo_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // About 45 beats over all tests with room for long random stalls
  localparam int TIMEOUT_CYCLES = 3000;

  logic              ACLK = 1'b0;
  logic              aresetn_rrr;
  addr_req_t         ar_req;
  addr_req_t         aw_req;
  logic              ar_valid, ar_ready, aw_valid, aw_ready;
  logic [DATA_W-1:0] w_data;
  logic              w_valid, w_ready;
  logic              b_valid, b_ready;
  logic [ID_W-1:0]   b_id, r_id;
  logic [1:0]        b_resp, r_resp;
  logic [DATA_W-1:0] r_data;
  logic              r_valid, r_last, r_ready;
  logic              user_write_deq, user_write_empty;
  logic [DATA_W-1:0] user_write_data;
  logic              user_read_enq, user_read_almost_full;
  logic [DATA_W-1:0] user_read_data;
  user_cmd_t         user_cmd;
  logic              user_done;

  // Scoreboard state
  integer            seed = 32'h9d36fa2b;
  string             test_name = "reset";
  int                cycle_count = 0;
  int                error_count = 0;
  logic              drain_en = 1'b1;
  logic [31:0]       rd_expect [$];
  logic [31:0]       wr_expect [$];
  int                rd_beats_total = 0;
  int                rd_base = 0;
  int                w_beats_total = 0;
  int                w_base = 0;
  int                b_count = 0;
  int                cmd_count = 0;
  logic [ID_W-1:0]   exp_rd_id, exp_wr_id;
  logic [LEN_W-1:0]  exp_rd_len, exp_wr_len;
  logic [7:0]        exp_cmd_addr;
  logic [8:0]        exp_cmd_size;
  logic              exp_cmd_read;

  always #20 ACLK = ~ACLK;

  axi_fifo_slave dut0 (.*);

  // ------------------------------
  // Check helpers
  // ------------------------------
  task automatic stop_with_failure(input string reason);
    error_count++;
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (actual === expected) else begin
      stop_with_failure($sformatf("error %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    assert (cond === 1'b1) else begin
      stop_with_failure(what);
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge ACLK);
    #2;
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic push_read_words(input int n);
    logic [31:0] word;
    int          i;
    for (i = 0; i < n; i++) begin
      next_cycle();
      // i words have landed in a FIFO that started empty
      check_eq({test_name, " read almost_full"}, i >= 13, user_read_almost_full);
      word = $random(seed);
      rd_expect.push_back(word);
      user_read_data = word;
      user_read_enq  = 1'b1;
    end
    next_cycle();
    user_read_enq = 1'b0;
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
                            input logic [7:0] len);
    exp_rd_id    = id;
    exp_rd_len   = len;
    exp_cmd_read = 1'b1;
    exp_cmd_addr = addr[7:0];
    exp_cmd_size = len + 1;
    rd_base      = rd_beats_total;
    next_cycle();
    ar_req   = '{id: id, addr: addr, len: len};
    ar_valid = 1'b1;
    do @(posedge ACLK); while (!ar_ready);
    #2;
    ar_valid = 1'b0;
    while (rd_beats_total - rd_base != len + 1) @(posedge ACLK);
  endtask

  task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
                             input logic [7:0] len);
    logic [31:0] word;
    int          i;
    int          resp_base;
    exp_wr_id    = id;
    exp_wr_len   = len;
    exp_cmd_read = 1'b0;
    exp_cmd_addr = addr[7:0];
    exp_cmd_size = len + 1;
    w_base       = w_beats_total;
    resp_base    = b_count;
    next_cycle();
    aw_req   = '{id: id, addr: addr, len: len};
    aw_valid = 1'b1;
    do @(posedge ACLK); while (!aw_ready);
    #2;
    aw_valid = 1'b0;
    for (i = 0; i <= len; i++) begin
      word = $random(seed);
      wr_expect.push_back(word);
      w_data  = word;
      w_valid = 1'b1;
      do @(posedge ACLK); while (!w_ready);
      #2;
    end
    w_valid = 1'b0;
    while (b_count == resp_base) @(posedge ACLK);
  endtask

  // Random R and B back-pressure
  initial begin : ready_driver
    integer rnd;
    r_ready = 1'b0;
    b_ready = 1'b0;
    forever begin
      @(posedge ACLK);
      rnd = $random(seed);
      #2;
      r_ready = rnd[0] | rnd[1];
      b_ready = rnd[2];
    end
  end

  // User side of the write FIFO
  initial begin : write_drain
    logic [31:0] exp_word;
    user_write_deq = 1'b0;
    forever begin
      next_cycle();
      user_write_deq = 1'b0;
      if (drain_en && aresetn_rrr && !user_write_empty) begin
        check_true("write FIFO holds a word that was never sent", wr_expect.size() != 0);
        exp_word = wr_expect.pop_front();
        check_eq({test_name, " user_write_data"}, exp_word, user_write_data);
        user_write_deq = 1'b1;
      end
    end
  end

  // ------------------------------
  // Monitors
  // ------------------------------
  always @(posedge ACLK) begin : channel_monitor
    logic [31:0] exp_word;
    if (aresetn_rrr) begin
      if (r_valid && r_ready) begin
        check_true("read beat arrived with no word queued", rd_expect.size() != 0);
        exp_word = rd_expect.pop_front();
        check_eq({test_name, " r_data"}, exp_word, r_data);
        check_eq({test_name, " r_id"}, exp_rd_id, r_id);
        check_eq({test_name, " r_resp"}, RESP_OKAY, r_resp);
        check_eq({test_name, " r_last"}, rd_beats_total - rd_base == exp_rd_len, r_last);
        rd_beats_total <= rd_beats_total + 1;
      end
      if (w_valid && w_ready) begin
        w_beats_total <= w_beats_total + 1;
      end
      if (b_valid && b_ready) begin
        check_eq({test_name, " b_id"}, exp_wr_id, b_id);
        check_eq({test_name, " b_resp"}, RESP_OKAY, b_resp);
        check_eq({test_name, " beats before B"}, exp_wr_len + 1, w_beats_total - w_base);
        b_count <= b_count + 1;
      end
      if (user_cmd.read_enable || user_cmd.write_enable) begin
        check_eq({test_name, " cmd addr"}, exp_cmd_addr, user_cmd.addr);
        check_eq({test_name, " cmd word_size"}, exp_cmd_size, user_cmd.word_size);
        check_eq({test_name, " cmd enables"}, exp_cmd_read ? 2'b10 : 2'b01,
                 {user_cmd.read_enable, user_cmd.write_enable});
        cmd_count <= cmd_count + 1;
      end
    end
  end

  always @(posedge ACLK) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("timeout after %0d cycles", cycle_count));
    end
  end

  // Protocol rules
  a_r_hold : assert property (@(posedge ACLK) disable iff (!aresetn_rrr)
    (r_valid && !r_ready) |=> (r_valid && $stable(r_data) && $stable(r_id) && $stable(r_last)))
    else stop_with_failure("R beat changed or dropped while stalled");

  a_b_hold : assert property (@(posedge ACLK) disable iff (!aresetn_rrr)
    (b_valid && !b_ready) |=> (b_valid && $stable(b_id)))
    else stop_with_failure("B response changed or dropped while stalled");

  a_b_once : assert property (@(posedge ACLK) disable iff (!aresetn_rrr)
    (b_valid && b_ready) |=> !b_valid)
    else stop_with_failure("B response repeated after its transfer");

  a_cmd_strobes : assert property (@(posedge ACLK) disable iff (!aresetn_rrr)
    (user_cmd.read_enable == ar_ready) && (user_cmd.write_enable == aw_ready))
    else stop_with_failure("user command strobe out of step with address ready");

  a_hold_off : assert property (@(posedge ACLK) disable iff (!aresetn_rrr)
    user_done |=> !(ar_ready || aw_ready))
    else stop_with_failure("burst accepted while user_done was high");

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : main
    int cmd_base;
    int taken;
    aresetn_rrr    = 1'b0;
    ar_req         = '0;
    ar_valid       = 1'b0;
    aw_req         = '0;
    aw_valid       = 1'b0;
    w_data         = '0;
    w_valid        = 1'b0;
    user_read_enq  = 1'b0;
    user_read_data = '0;
    user_done      = 1'b0;
    repeat (2) @(posedge ACLK);
    #2;
    check_eq("reset controls", 32'h0, {ar_ready, aw_ready, w_ready, b_valid, r_valid, r_last,
             user_cmd.read_enable, user_cmd.write_enable, user_read_almost_full});
    check_eq("reset user_write_empty", 32'h1, user_write_empty);
    aresetn_rrr = 1'b1;

    test_name = "read_burst";
    push_read_words(8);
    read_burst(4'ha, 32'h0000_1f20, 8'd7);

    test_name = "write_burst";
    write_burst(4'h5, 32'h1234_56c8, 8'd5);
    while (wr_expect.size() != 0 || !user_write_empty) @(posedge ACLK);

    // AR waits until the user side is no longer busy
    test_name = "hold_off";
    push_read_words(2);
    cmd_base  = cmd_count;
    user_done = 1'b1;
    fork
      read_burst(4'h3, 32'h0000_0a40, 8'd1);
      begin
        repeat (8) @(posedge ACLK);
        check_eq("hold_off commands", cmd_base, cmd_count);
        #2;
        user_done = 1'b0;
      end
    join

    test_name = "almost_full";
    push_read_words(13);
    check_eq("almost_full read flag", 32'h1, user_read_almost_full);
    read_burst(4'hc, 32'h0000_3300, 8'd12);
    drain_en = 1'b0;
    fork
      write_burst(4'h9, 32'h0000_77e4, 8'd15);
    join_none
    repeat (40) @(posedge ACLK);
    taken = w_beats_total - w_base;
    check_true("write burst did not stall near the almost-full mark", taken >= 13 && taken < 16);
    check_eq("almost_full w_ready", 32'h0, w_ready);
    check_eq("almost_full b_valid", 32'h0, b_valid);
    drain_en = 1'b1;
    wait fork;
    while (wr_expect.size() != 0 || !user_write_empty) @(posedge ACLK);

    test_name = "final";
    repeat (4) @(posedge ACLK);
    check_eq("final commands", 32'd5, cmd_count);
    check_eq("final responses", 32'd2, b_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stop_with_failure("checks failed during the run");
    end
  end

endmodule

`default_nettype wire

//--- logic/axi_fifo_slave.sv
`default_nettype none

module axi_fifo_slave import axi_fifo_pkg::*; (
  input  logic              ACLK,
  input  logic              aresetn_rrr,
  // AXI address channels
  input  addr_req_t         ar_req,
  input  logic              ar_valid,
  output logic              ar_ready,
  input  addr_req_t         aw_req,
  input  logic              aw_valid,
  output logic              aw_ready,
  // AXI write data and response
  input  logic [DATA_W-1:0] w_data,
  input  logic              w_valid,
  output logic              w_ready,
  output logic              b_valid,
  output logic [ID_W-1:0]   b_id,
  output logic [1:0]        b_resp,
  input  logic              b_ready,
  // AXI read data
  output logic              r_valid,
  output logic [DATA_W-1:0] r_data,
  output logic [ID_W-1:0]   r_id,
  output logic [1:0]        r_resp,
  output logic              r_last,
  input  logic              r_ready,
  // User side
  input  logic              user_write_deq,
  output logic [DATA_W-1:0] user_write_data,
  output logic              user_write_empty,
  input  logic              user_read_enq,
  input  logic [DATA_W-1:0] user_read_data,
  output logic              user_read_almost_full,
  output user_cmd_t         user_cmd,
  input  logic              user_done
);

  burst_t            rd_burst;
  burst_t            wr_burst;
  logic              rd_finish;
  logic              wr_finish;
  logic              wr_fifo_enq;
  logic [DATA_W-1:0] wr_fifo_data;
  logic              wr_fifo_almost_full;
  logic              rd_fifo_deq;
  logic [DATA_W-1:0] rd_fifo_data;
  logic              rd_fifo_empty;

  burst_arbiter arb0 (
    .ACLK(ACLK), .aresetn_rrr(aresetn_rrr),
    .ar_req(ar_req), .ar_valid(ar_valid), .aw_req(aw_req), .aw_valid(aw_valid),
    .user_done(user_done), .rd_finish(rd_finish), .wr_finish(wr_finish),
    .ar_ready(ar_ready), .aw_ready(aw_ready),
    .rd_burst(rd_burst), .wr_burst(wr_burst), .user_cmd(user_cmd)
  );

  read_beat_engine rd_eng0 (
    .ACLK(ACLK), .aresetn_rrr(aresetn_rrr), .rd_burst(rd_burst),
    .fifo_data(rd_fifo_data), .fifo_empty(rd_fifo_empty), .r_ready(r_ready),
    .fifo_deq(rd_fifo_deq), .r_valid(r_valid), .r_data(r_data), .r_id(r_id),
    .r_resp(r_resp), .r_last(r_last), .rd_finish(rd_finish)
  );

  write_beat_engine wr_eng0 (
    .ACLK(ACLK), .aresetn_rrr(aresetn_rrr), .wr_burst(wr_burst),
    .w_data(w_data), .w_valid(w_valid), .fifo_almost_full(wr_fifo_almost_full),
    .b_ready(b_ready), .w_ready(w_ready), .fifo_enq(wr_fifo_enq),
    .fifo_data(wr_fifo_data), .b_valid(b_valid), .b_id(b_id), .b_resp(b_resp),
    .wr_finish(wr_finish)
  );

  // AXI to user
  data_fifo wr_fifo0 (
    .ACLK(ACLK), .aresetn_rrr(aresetn_rrr),
    .enq(wr_fifo_enq), .data_in(wr_fifo_data), .deq(user_write_deq),
    .data_out(user_write_data), .empty(user_write_empty),
    .almost_full(wr_fifo_almost_full)
  );

  // User to AXI
  data_fifo rd_fifo0 (
    .ACLK(ACLK), .aresetn_rrr(aresetn_rrr),
    .enq(user_read_enq), .data_in(user_read_data), .deq(rd_fifo_deq),
    .data_out(rd_fifo_data), .empty(rd_fifo_empty),
    .almost_full(user_read_almost_full)
  );

endmodule

`default_nettype wire

//--- logic/write_beat_engine.sv
`default_nettype none

module write_beat_engine import axi_fifo_pkg::*; (
  input  logic              ACLK,
  input  logic              aresetn_rrr,
  input  burst_t            wr_burst,
  input  logic [DATA_W-1:0] w_data,
  input  logic              w_valid,
  input  logic              fifo_almost_full,
  input  logic              b_ready,
  output logic              w_ready,
  output logic              fifo_enq,
  output logic [DATA_W-1:0] fifo_data,
  output logic              b_valid,
  output logic [ID_W-1:0]   b_id,
  output logic [1:0]        b_resp,
  output logic              wr_finish
);

  logic [LEN_W:0] beat_cnt;
  logic [LEN_W:0] beat_nxt;
  logic           w_take;

  assign w_take    = w_valid && w_ready;
  assign beat_nxt  = beat_cnt + w_take;
  assign b_resp    = RESP_OKAY;
  assign wr_finish = b_valid && b_ready;

  // ------------------------------
  // W acceptance and B response
  // ------------------------------
  always_ff @(posedge ACLK) begin
    if (!aresetn_rrr) begin
      beat_cnt <= '0;
      w_ready  <= 1'b0;
      fifo_enq <= 1'b0;
      b_valid  <= 1'b0;
    end else begin
      fifo_enq <= w_take;

      // Look at the count after this cycle so no beat is taken twice
      w_ready <= wr_burst.active && (beat_nxt <= {1'b0, wr_burst.len}) &&
                 !fifo_almost_full;

      if (!wr_burst.active) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_nxt;
      end

      // One response per burst
      if (w_take && (beat_cnt == {1'b0, wr_burst.len})) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  // Payload
  always_ff @(posedge ACLK) begin
    if (w_take) begin
      fifo_data <= w_data;
    end
    if (w_take && (beat_cnt == {1'b0, wr_burst.len})) begin
      b_id <= wr_burst.id;
    end
  end

endmodule

`default_nettype wire

//--- logic/read_beat_engine.sv
`default_nettype none

module read_beat_engine import axi_fifo_pkg::*; (
  input  logic              ACLK,
  input  logic              aresetn_rrr,
  input  burst_t            rd_burst,
  input  logic [DATA_W-1:0] fifo_data,
  input  logic              fifo_empty,
  input  logic              r_ready,
  output logic              fifo_deq,
  output logic              r_valid,
  output logic [DATA_W-1:0] r_data,
  output logic [ID_W-1:0]   r_id,
  output logic [1:0]        r_resp,
  output logic              r_last,
  output logic              rd_finish
);

  // Beats already loaded into the R register
  logic [LEN_W:0] beat_cnt;
  logic           more_beats;
  logic           out_free;

  assign more_beats = rd_burst.active && (beat_cnt <= {1'b0, rd_burst.len});
  assign out_free   = !r_valid || r_ready;
  assign fifo_deq   = more_beats && out_free && !fifo_empty;
  assign r_resp     = RESP_OKAY;

  // ------------------------------
  // R channel control
  // ------------------------------
  always_ff @(posedge ACLK) begin
    if (!aresetn_rrr) begin
      beat_cnt  <= '0;
      r_valid   <= 1'b0;
      r_last    <= 1'b0;
      rd_finish <= 1'b0;
    end else begin
      rd_finish <= r_valid && r_ready && r_last;

      if (!rd_burst.active) begin
        beat_cnt <= '0;
      end

      if (fifo_deq) begin
        r_valid  <= 1'b1;
        r_last   <= (beat_cnt == {1'b0, rd_burst.len});
        beat_cnt <= beat_cnt + 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
        r_last  <= 1'b0;
      end
    end
  end

  // Beat payload
  always_ff @(posedge ACLK) begin
    if (fifo_deq) begin
      r_data <= fifo_data;
      r_id   <= rd_burst.id;
    end
  end

  a_r_hold : assert property (@(posedge ACLK) disable iff (!aresetn_rrr)
    (r_valid && !r_ready) |=> (r_valid && $stable(r_data) && $stable(r_last)));

endmodule

`default_nettype wire

//--- logic/burst_arbiter.sv
`default_nettype none

module burst_arbiter import axi_fifo_pkg::*; (
  input  logic      ACLK,
  input  logic      aresetn_rrr,
  input  addr_req_t ar_req,
  input  logic      ar_valid,
  input  addr_req_t aw_req,
  input  logic      aw_valid,
  input  logic      user_done,
  input  logic      rd_finish,
  input  logic      wr_finish,
  output logic      ar_ready,
  output logic      aw_ready,
  output burst_t    rd_burst,
  output burst_t    wr_burst,
  output user_cmd_t user_cmd
);

  logic idle;
  logic take_rd;
  logic take_wr;

  // One burst at a time, user_done acts as a hold-off
  assign idle    = !rd_burst.active && !wr_burst.active;
  assign take_rd = idle && ar_valid && !user_done;
  assign take_wr = idle && aw_valid && !user_done && !ar_valid;

  // ------------------------------
  // Burst ownership
  // ------------------------------
  always_ff @(posedge ACLK) begin
    if (!aresetn_rrr) begin
      ar_ready               <= 1'b0;
      aw_ready               <= 1'b0;
      rd_burst               <= '0;
      wr_burst               <= '0;
      user_cmd.read_enable   <= 1'b0;
      user_cmd.write_enable  <= 1'b0;
    end else begin
      // ready and enables are one-cycle pulses
      ar_ready              <= take_rd;
      aw_ready              <= take_wr;
      user_cmd.read_enable  <= take_rd;
      user_cmd.write_enable <= take_wr;

      if (take_rd) begin
        rd_burst <= '{active: 1'b1, id: ar_req.id, len: ar_req.len};
      end else if (rd_finish) begin
        rd_burst.active <= 1'b0;
      end

      if (take_wr) begin
        wr_burst <= '{active: 1'b1, id: aw_req.id, len: aw_req.len};
      end else if (wr_finish) begin
        wr_burst.active <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Command register
  // ------------------------------
  always_ff @(posedge ACLK) begin
    if (take_rd) begin
      user_cmd.addr      <= ar_req.addr[USER_ADDR_W-1:0];
      user_cmd.word_size <= {1'b0, ar_req.len} + 1'b1;
    end else if (take_wr) begin
      user_cmd.addr      <= aw_req.addr[USER_ADDR_W-1:0];
      user_cmd.word_size <= {1'b0, aw_req.len} + 1'b1;
    end
  end

  a_one_burst : assert property (@(posedge ACLK) disable iff (!aresetn_rrr)
    !(rd_burst.active && wr_burst.active));

endmodule

`default_nettype wire

//--- logic/data_fifo.sv
`default_nettype none

module data_fifo import axi_fifo_pkg::*; (
  input  logic              ACLK,
  input  logic              aresetn_rrr,
  input  logic              enq,
  input  logic [DATA_W-1:0] data_in,
  input  logic              deq,
  output logic [DATA_W-1:0] data_out,
  output logic              empty,
  output logic              almost_full
);

  localparam int DEPTH = 1 << FIFO_ADDR_W;

  logic [DATA_W-1:0]      mem [DEPTH];
  logic [FIFO_ADDR_W-1:0] head;
  logic [FIFO_ADDR_W-1:0] tail;
  logic [FIFO_ADDR_W:0]   count;
  logic [FIFO_ADDR_W:0]   count_nxt;

  // Occupancy after this cycle's strobes
  always_comb begin
    count_nxt = count;
    if (enq && !deq) begin
      count_nxt = count + 1'b1;
    end else if (deq && !enq) begin
      count_nxt = count - 1'b1;
    end
  end

  // ------------------------------
  // Pointers and flags
  // ------------------------------
  always_ff @(posedge ACLK) begin
    if (!aresetn_rrr) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      empty       <= 1'b1;
      almost_full <= 1'b0;
    end else begin
      // Pointers wrap on their own at the depth
      if (enq) begin
        head <= head + 1'b1;
      end
      if (deq) begin
        tail <= tail + 1'b1;
      end
      count       <= count_nxt;
      empty       <= (count_nxt == '0);
      almost_full <= (count_nxt >= DEPTH - ALMOST_FULL_MARGIN);
    end
  end

  // Storage
  always_ff @(posedge ACLK) begin
    if (enq) begin
      mem[head] <= data_in;
    end
  end

  // First word falls through
  assign data_out = mem[tail];

  // ------------------------------
  // Checks
  // ------------------------------
  a_no_overflow : assert property (@(posedge ACLK) disable iff (!aresetn_rrr)
    enq |-> (count != DEPTH));

  a_no_underflow : assert property (@(posedge ACLK) disable iff (!aresetn_rrr)
    deq |-> !empty);

endmodule

`default_nettype wire

//--- logic/axi_fifo_pkg.sv
`default_nettype none

package axi_fifo_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int ID_W        = 4;
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int LEN_W       = 8;
  localparam int USER_ADDR_W = 8;
  localparam int WORD_CNT_W  = 9;

  // FIFO geometry, depth is 2**FIFO_ADDR_W
  localparam int FIFO_ADDR_W        = 4;
  localparam int ALMOST_FULL_MARGIN = 3;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // ------------------------------
  // Bundles
  // ------------------------------

  // Address request, same layout on AR and AW
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } addr_req_t;

  // Burst currently owned by one beat engine
  typedef struct packed {
    logic              active;
    logic [ID_W-1:0]   id;
    logic [LEN_W-1:0]  len;
  } burst_t;

  // Command towards user logic
  typedef struct packed {
    logic [USER_ADDR_W-1:0] addr;
    logic [WORD_CNT_W-1:0]  word_size;
    logic                   read_enable;
    logic                   write_enable;
  } user_cmd_t;

endpackage

`default_nettype wire
